// File: include/drivers_conf.svh
`ifndef DRIVERS_CONF_SVH
`define DRIVERS_CONF_SVH

// Boot-time function-control word
// Shifted MSB first on every lane after FCWRTEN
// Latched by WRTFC on its last 5 bits
localparam logic [CONF_BITS-1:0] DRV_CONF_DEFAULT = 48'h9600_7F7F_7F04;

`endif

// File: logic/panel_pkg.sv
package panel_pkg;

   // Panel geometry
   // Parallel driver chains sharing SCLK, GCLK and LAT
   localparam int LANES = 30;
   // Gray depth of one color
   localparam int GRAY_BITS = 16;
   // Driver shift register length, one segment of slices
   localparam int SEG_BITS = 48;

   // One SIN bit per lane, shifted on a single SCLK edge
   typedef logic [LANES-1:0] slice_t;

   // Gray values of one LED
   // Red sits in the top bits so the flat vector reads red, green, blue MSB first
   typedef struct packed {
      logic [GRAY_BITS-1:0] red;
      logic [GRAY_BITS-1:0] green;
      logic [GRAY_BITS-1:0] blue;
   } rgb_t;

   // One LED position on every lane
   // Payload of the pixel port, 1440 bits
   typedef struct packed {
      rgb_t [LANES-1:0] lane;
   } led_group_t;

endpackage

// File: logic/drv_pkg.sv
package drv_pkg;

   // Controller states
   // Boot goes STALL, CONFIG, WAIT_SYNC, then STREAM until reset
   typedef enum logic [1:0] {
      STALL,
      CONFIG,
      WAIT_SYNC,
      STREAM
   } drv_state_t;

   // LAT commands, told apart by SCLK edges seen with LAT high
   typedef enum logic [2:0] {
      NO_LAT,
      FCWRTEN,
      WRTFC,
      WRTGS,
      LATGS
   } lat_cmd_t;

   // SCLK edges with LAT high per command
   localparam int FCWRTEN_EDGES = 15;
   localparam int WRTFC_EDGES = 5;
   localparam int WRTGS_EDGES = 1;
   localparam int LATGS_EDGES = 3;

   // Function-control word length
   localparam int CONF_BITS = 48;

   `include "drivers_conf.svh"

   // Run length of LAT for a command
   function automatic int lat_edges(lat_cmd_t cmd);
      case (cmd)
         FCWRTEN: return FCWRTEN_EDGES;
         WRTFC:   return WRTFC_EDGES;
         WRTGS:   return WRTGS_EDGES;
         LATGS:   return LATGS_EDGES;
         default: return 0;
      endcase
   endfunction

endpackage

// File: logic/bitplane_slicer.sv
`timescale 1ns/100ps

module bitplane_slicer (
   input  logic                  clk_33,
   input  logic                  nrst,
   // Four-phase req/ack pixel port
   input  logic                  pix_req,
   input  panel_pkg::led_group_t pix_data,
   output logic                  pix_ack,
   // Slice FIFO write side
   output logic                  push,
   output panel_pkg::slice_t     push_data,
   input  logic                  full
);
   import panel_pkg::*;

   localparam int IDX_W = $clog2(SEG_BITS);

   // Group being sliced
   led_group_t group;
   // Current bit plane with 0 as red MSB
   logic [IDX_W-1:0] bit_idx;
   // Slices of the held group still to push
   logic busy;
   // New request seen while idle
   logic take;

   assign take = pix_req && !pix_ack;

   // One slice per cycle unless the FIFO is full
   assign push = busy && !full;

   // Same flat bit of every lane's rgb_t
   // Index 0 picks bit 47 as the red MSB
   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         push_data[l] = group.lane[l][IDX_W'(SEG_BITS - 1) - bit_idx];
      end
   end

   // Group capture
   always_ff @(posedge clk_33) begin
      if (take) begin
         group <= pix_data;
      end
   end

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         pix_ack <= 1'b0;
         busy    <= 1'b0;
         bit_idx <= '0;
      end else begin
         if (take) begin
            // Ack goes up with the capture
            pix_ack <= 1'b1;
            busy    <= 1'b1;
            bit_idx <= '0;
         end else if (push) begin
            if (bit_idx == IDX_W'(SEG_BITS - 1)) begin
               busy    <= 1'b0;
               bit_idx <= '0;
            end else begin
               bit_idx <= bit_idx + 1'b1;
            end
         end else if (pix_ack && !busy && !pix_req) begin
            // All slices out and req gone
            pix_ack <= 1'b0;
         end
      end
   end

   // Source holds pix_req until the ack is up
   assert property (@(posedge clk_33) disable iff (!nrst) $fell(pix_req) |-> pix_ack)
      else $error("pix_req dropped before pix_ack");

   // Source keeps data steady until the ack is seen
   assert property (@(posedge clk_33) disable iff (!nrst)
      pix_req && !pix_ack |=> $stable(pix_data))
      else $error("pix_data changed before pix_ack");

endmodule

// File: logic/slice_fifo.sv
`timescale 1ns/100ps

module slice_fifo #(
   parameter int FIFO_DEPTH = 64
) (
   input  logic              clk_33,
   input  logic              nrst,
   // Write side
   input  logic              push,
   input  panel_pkg::slice_t push_data,
   output logic              full,
   // Read side, show-ahead
   input  logic              pop,
   output panel_pkg::slice_t pop_data,
   output logic              empty
);
   import panel_pkg::*;

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // Storage
   slice_t mem [0:FIFO_DEPTH-1];

   // Pointers carry one wrap bit above the address
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;

   // Same address and same wrap means empty
   assign empty = (wr_ptr == rd_ptr);
   // Same address, opposite wrap means full
   assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // Head slice, valid while not empty
   assign pop_data = mem[rd_ptr[ADDR_W-1:0]];

   always_ff @(posedge clk_33) begin
      if (push) begin
         mem[wr_ptr[ADDR_W-1:0]] <= push_data;
      end
   end

   // Push and pop may land on the same edge
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Producer respects full
   assert property (@(posedge clk_33) disable iff (!nrst) push |-> !full)
      else $error("push into full slice FIFO");

   // Consumer respects empty
   assert property (@(posedge clk_33) disable iff (!nrst) pop |-> !empty)
      else $error("pop from empty slice FIFO");

endmodule

// File: logic/driver_main_controller.sv
`timescale 1ns/100ps

module driver_main_controller #(
   parameter int BLANKING_TIME = 80,
   parameter int SEG_PER_FRAME = 9
) (
   input  logic              clk_33,
   input  logic              nrst,
   // Frame start pulse
   input  logic              frame_sync,
   // Slice FIFO read side
   output logic              pop,
   input  panel_pkg::slice_t pop_data,
   input  logic              empty,
   // Driver chain outputs
   output logic              driver_sclk,
   output logic              driver_gclk,
   output logic              driver_lat,
   output panel_pkg::slice_t drivers_sin
);
   import panel_pkg::*;
   import drv_pkg::*;

   // FCWRTEN edges then the configuration word
   localparam int CFG_EDGES = FCWRTEN_EDGES + CONF_BITS;
   localparam int BLANK_W = $clog2(BLANKING_TIME + 1);
   localparam int BIT_W = $clog2(SEG_BITS);
   localparam int SEG_W = $clog2(SEG_PER_FRAME + 1);

   drv_state_t state;
   // Bit position inside CONFIG
   logic [5:0] cfg_phase;
   // Configuration bit for the current phase
   logic [5:0] conf_idx;
   // Blanking cycles done in this frame
   logic [BLANK_W-1:0] blank_cnt;
   // Frame bit counter as bit in segment and segment
   logic [BIT_W-1:0] seg_bit;
   logic [SEG_W-1:0] seg_idx;
   logic blanking;
   logic last_seg;
   // A bit goes out on SCLK this cycle
   logic bit_go;
   slice_t sin_next;
   // Command starting on the current bit
   lat_cmd_t issue;
   // Command sequencer
   lat_cmd_t lat_cmd;
   logic [3:0] lat_left;
   // Clock gate enables
   logic sclk_en;
   logic gclk_en;

   assign blanking = (blank_cnt < BLANK_W'(BLANKING_TIME));
   assign last_seg = (seg_idx == SEG_W'(SEG_PER_FRAME - 1));

   // Data bits leave only after blanking and only with a slice ready
   assign pop = (state == STREAM) && !blanking && !empty;
   // Every CONFIG cycle carries a bit
   assign bit_go = (state == CONFIG) || pop;

   // Phase 15 maps to bit 47
   assign conf_idx = 6'(CFG_EDGES - 1) - cfg_phase;

   // SIN source
   always_comb begin
      sin_next = '0;
      if (state == CONFIG) begin
         // FCWRTEN shifts zeros
         if (cfg_phase >= 6'(FCWRTEN_EDGES)) begin
            sin_next = {LANES{DRV_CONF_DEFAULT[conf_idx]}};
         end
      end else if (pop) begin
         sin_next = pop_data;
      end
   end

   // Command start points
   always_comb begin
      issue = NO_LAT;
      if (state == CONFIG) begin
         if (cfg_phase == '0) begin
            issue = FCWRTEN;
         end else if (cfg_phase == 6'(CFG_EDGES - WRTFC_EDGES)) begin
            // Last 5 bits of the word
            issue = WRTFC;
         end
      end else if (pop) begin
         if (last_seg && seg_bit == BIT_W'(SEG_BITS - LATGS_EDGES)) begin
            // Bits 45 to 47 of the last segment
            issue = LATGS;
         end else if (!last_seg && seg_bit == BIT_W'(SEG_BITS - 1)) begin
            issue = WRTGS;
         end
      end
   end

   // Main FSM and counters
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         state     <= STALL;
         cfg_phase <= '0;
         blank_cnt <= '0;
         seg_bit   <= '0;
         seg_idx   <= '0;
      end else begin
         case (state)
            STALL: begin
               state <= CONFIG;
            end
            CONFIG: begin
               cfg_phase <= cfg_phase + 1'b1;
               if (cfg_phase == 6'(CFG_EDGES - 1)) begin
                  state <= WAIT_SYNC;
               end
            end
            WAIT_SYNC: begin
               // Frame counters start clean
               blank_cnt <= '0;
               seg_bit   <= '0;
               seg_idx   <= '0;
               if (frame_sync) begin
                  state <= STREAM;
               end
            end
            STREAM: begin
               if (blanking) begin
                  blank_cnt <= blank_cnt + 1'b1;
               end else if (pop) begin
                  // Advance only on popped slices
                  if (seg_bit == BIT_W'(SEG_BITS - 1)) begin
                     seg_bit <= '0;
                     if (last_seg) begin
                        // Next frame opens with blanking
                        seg_idx   <= '0;
                        blank_cnt <= '0;
                     end else begin
                        seg_idx <= seg_idx + 1'b1;
                     end
                  end else begin
                     seg_bit <= seg_bit + 1'b1;
                  end
               end
            end
            default: begin
               state <= STALL;
            end
         endcase
      end
   end

   // LAT sequencer
   // LAT drops on the cycle after the last edge of a command
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         lat_cmd    <= NO_LAT;
         lat_left   <= '0;
         driver_lat <= 1'b0;
      end else begin
         if (issue != NO_LAT) begin
            lat_cmd    <= issue;
            lat_left   <= 4'(lat_edges(issue) - 1);
            driver_lat <= 1'b1;
         end else if (lat_cmd != NO_LAT) begin
            if (lat_left == '0) begin
               lat_cmd    <= NO_LAT;
               driver_lat <= 1'b0;
            end else if (bit_go) begin
               // High is held across FIFO stalls
               lat_left   <= lat_left - 1'b1;
               driver_lat <= 1'b1;
            end
         end
      end
   end

   // SIN and clock enables
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         sclk_en     <= 1'b0;
         gclk_en     <= 1'b0;
         drivers_sin <= '0;
      end else begin
         sclk_en     <= bit_go;
         gclk_en     <= (state == STREAM);
         drivers_sin <= sin_next;
      end
   end

   // Rising edges land mid-cycle on registered SIN and LAT
   assign driver_sclk = ~clk_33 & sclk_en;
   assign driver_gclk = ~clk_33 & gclk_en;

   // LAT only follows CONFIG or STREAM cycles
   assert property (@(posedge clk_33) disable iff (!nrst)
      driver_lat |-> $past(state == CONFIG || state == STREAM))
      else $error("LAT high outside CONFIG and STREAM");

   // Every LAT run opens on a clocked bit
   assert property (@(posedge clk_33) disable iff (!nrst) $rose(driver_lat) |-> sclk_en)
      else $error("LAT rose without an SCLK edge");

endmodule

// File: logic/led_panel_top.sv
`timescale 1ns/100ps

module led_panel_top #(
   parameter int SEG_PER_FRAME = 9,
   // GCLK budget of 512 minus the data edges
   parameter int BLANKING_TIME = 512 - SEG_PER_FRAME * panel_pkg::SEG_BITS,
   // Power of two
   parameter int FIFO_DEPTH = 64
) (
   input  logic                  clk_33,
   input  logic                  nrst,
   // Pixel port
   input  logic                  pix_req,
   input  panel_pkg::led_group_t pix_data,
   output logic                  pix_ack,
   // Frame start
   input  logic                  frame_sync,
   // Driver chains
   output logic                  driver_sclk,
   output logic                  driver_gclk,
   output logic                  driver_lat,
   output panel_pkg::slice_t     drivers_sin
);
   import panel_pkg::*;

   // Slicer to FIFO
   logic   push;
   slice_t push_data;
   logic   full;
   // FIFO to controller
   logic   pop;
   slice_t pop_data;
   logic   empty;

   // Groups in, bit planes out
   bitplane_slicer slicer_i (
      .clk_33    (clk_33),
      .nrst      (nrst),
      .pix_req   (pix_req),
      .pix_data  (pix_data),
      .pix_ack   (pix_ack),
      .push      (push),
      .push_data (push_data),
      .full      (full)
   );

   // Absorbs blanking and input gaps
   slice_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_i (
      .clk_33    (clk_33),
      .nrst      (nrst),
      .push      (push),
      .push_data (push_data),
      .full      (full),
      .pop       (pop),
      .pop_data  (pop_data),
      .empty     (empty)
   );

   // Boot config, then frames
   driver_main_controller #(
      .BLANKING_TIME (BLANKING_TIME),
      .SEG_PER_FRAME (SEG_PER_FRAME)
   ) ctrl_i (
      .clk_33      (clk_33),
      .nrst        (nrst),
      .frame_sync  (frame_sync),
      .pop         (pop),
      .pop_data    (pop_data),
      .empty       (empty),
      .driver_sclk (driver_sclk),
      .driver_gclk (driver_gclk),
      .driver_lat  (driver_lat),
      .drivers_sin (drivers_sin)
   );

endmodule

// File: tests/tb_led_panel.sv
`timescale 1ns/100ps

module tb_led_panel;
   import panel_pkg::*;
   import drv_pkg::*;

   localparam int BLANKING_TIME = 80;
   localparam int SEG_PER_FRAME = 9;
   localparam int FRAMES = 4;
   localparam int CFG_EDGES = FCWRTEN_EDGES + CONF_BITS;
   localparam int FRAME_EDGES = SEG_PER_FRAME * SEG_BITS;
   localparam int HS_LIMIT = 2000;

   logic clk_33;
   logic nrst;
   logic pix_req;
   led_group_t pix_data;
   logic pix_ack;
   logic frame_sync;
   logic driver_sclk;
   logic driver_gclk;
   logic driver_lat;
   slice_t drivers_sin;

   // Expected slices with the oldest first
   slice_t ref_q[$];
   logic [31:0] rng_state = 32'h67b6;
   int slice_errs = 0;
   int conf_errs = 0;
   int lat_errs = 0;
   int gap_errs = 0;
   int other_errs = 0;
   // Driver chain model state
   int unsigned sclk_edges = 0;
   int unsigned gclk_run = 0;
   int unsigned lat_run = 0;
   int unsigned run_start = 0;
   logic [CONF_BITS-1:0] conf_seen = '0;
   bit sync_sent = 0;
   int sync_delay;
   logic req_q = 1'b0;
   logic ack_q = 1'b0;

   led_panel_top dut_i (
      .clk_33      (clk_33),
      .nrst        (nrst),
      .pix_req     (pix_req),
      .pix_data    (pix_data),
      .pix_ack     (pix_ack),
      .frame_sync  (frame_sync),
      .driver_sclk (driver_sclk),
      .driver_gclk (driver_gclk),
      .driver_lat  (driver_lat),
      .drivers_sin (drivers_sin)
   );

   initial begin
      clk_33 = 1'b0;
      forever #4 clk_33 = ~clk_33;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_word();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   function automatic led_group_t random_group();
      led_group_t g;
      logic [31:0] r;
      for (int l = 0; l < LANES; l++) begin
         r = rand_word();
         g.lane[l].red = r[31:16];
         g.lane[l].green = r[15:0];
         r = rand_word();
         g.lane[l].blue = r[23:8];
      end
      return g;
   endfunction

   // Red then green then blue bit planes MSB first on every lane
   task automatic queue_slices(input led_group_t g);
      slice_t s;
      for (int i = 0; i < SEG_BITS; i++) begin
         for (int l = 0; l < LANES; l++) begin
            if (i < GRAY_BITS)
               s[l] = g.lane[l].red[GRAY_BITS-1-i];
            else if (i < 2*GRAY_BITS)
               s[l] = g.lane[l].green[2*GRAY_BITS-1-i];
            else
               s[l] = g.lane[l].blue[3*GRAY_BITS-1-i];
         end
         ref_q.push_back(s);
      end
   endtask

   // Command expected at a given SCLK edge since boot
   function automatic lat_cmd_t lat_at(input int unsigned e);
      int unsigned b;
      if (e < FCWRTEN_EDGES)
         return FCWRTEN;
      if (e < CFG_EDGES)
         return (e >= CFG_EDGES - WRTFC_EDGES) ? WRTFC : NO_LAT;
      b = (e - CFG_EDGES) % FRAME_EDGES;
      if (b / SEG_BITS == SEG_PER_FRAME - 1)
         return (b % SEG_BITS >= SEG_BITS - LATGS_EDGES) ? LATGS : NO_LAT;
      return (b % SEG_BITS == SEG_BITS - 1) ? WRTGS : NO_LAT;
   endfunction

   // Expected LAT run length starting at an edge
   function automatic int run_from(input int unsigned e);
      int n;
      n = 0;
      if (lat_at(e) != NO_LAT) begin
         while (lat_at(e + n) == lat_at(e))
            n++;
      end
      return n;
   endfunction

   task automatic check_slice(input string name, input slice_t exp, input slice_t act);
      if (act !== exp) begin
         slice_errs++;
         $display("FAIL %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_conf(input string name, input logic [CONF_BITS-1:0] exp,
                             input logic [CONF_BITS-1:0] act);
      if (act !== exp) begin
         conf_errs++;
         $display("FAIL %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_lat(input string name, input lat_cmd_t cmd, input int exp, input int act);
      if (act != exp) begin
         lat_errs++;
         $display("FAIL %s: expected %s over %0d edges actual %0d edges", name, cmd.name(),
                  exp, act);
      end
   endtask

   task automatic check_gap(input string name, input int lo, input int hi, input int act);
      if (act < lo || act > hi) begin
         gap_errs++;
         $display("FAIL %s: expected %0d to %0d GCLK cycles actual %0d", name, lo, hi, act);
      end
   endtask

   task automatic print_counts();
      $display("Errors: slice %0d, conf %0d, lat %0d, gap %0d, other %0d",
               slice_errs, conf_errs, lat_errs, gap_errs, other_errs);
   endtask

   task automatic abort_run(input string what);
      other_errs++;
      $display("Timeout: %s", what);
      print_counts();
      $display("Test failed");
      $finish;
   endtask

   // One SCLK edge as seen by the driver chain
   task automatic sample_chain();
      int unsigned d;
      slice_t exp;
      lat_cmd_t cmd;
      if (driver_gclk && !sync_sent) begin
         other_errs++;
         $display("GCLK running before frame sync");
      end
      if (!driver_sclk) begin
         if (driver_gclk)
            gclk_run++;
         return;
      end
      cmd = lat_at(sclk_edges);
      if (sclk_edges < CFG_EDGES) begin
         // FCWRTEN shifts zeros and then one word bit on every lane
         exp = '0;
         if (sclk_edges >= FCWRTEN_EDGES) begin
            exp = {LANES{DRV_CONF_DEFAULT[CFG_EDGES-1-sclk_edges]}};
            conf_seen = {conf_seen[CONF_BITS-2:0], drivers_sin[0]};
         end
         check_slice($sformatf("config edge %0d", sclk_edges), exp, drivers_sin);
         if (sclk_edges == CFG_EDGES - 1)
            check_conf("config word", DRV_CONF_DEFAULT, conf_seen);
      end else begin
         d = sclk_edges - CFG_EDGES;
         if (!sync_sent) begin
            other_errs++;
            $display("SCLK edge while waiting for frame sync");
         end
         // First frame after sync finds the FIFO filled
         if (d % FRAME_EDGES == 0)
            check_gap($sformatf("blanking before frame %0d", d / FRAME_EDGES), BLANKING_TIME,
                      (d == 0) ? BLANKING_TIME : 32'h7fff_ffff, gclk_run);
         if (ref_q.size() == 0) begin
            other_errs++;
            $display("Data SCLK edge with no slice sent, edge %0d", sclk_edges);
         end else begin
            check_slice($sformatf("frame %0d bit %0d", d / FRAME_EDGES, d % FRAME_EDGES),
                        ref_q.pop_front(), drivers_sin);
         end
      end
      // LAT runs checked when they end
      if (driver_lat) begin
         if (lat_run == 0)
            run_start = sclk_edges;
         lat_run++;
      end else begin
         if (lat_run != 0) begin
            check_lat($sformatf("latch run from edge %0d", run_start), lat_at(run_start),
                      run_from(run_start), lat_run);
            lat_run = 0;
         end
         if (cmd != NO_LAT && (sclk_edges == 0 || lat_at(sclk_edges - 1) != cmd))
            check_lat($sformatf("latch at edge %0d", sclk_edges), cmd, run_from(sclk_edges), 0);
      end
      gclk_run = 0;
      sclk_edges++;
   endtask

   // Both driver clocks stay high through the low half of clk_33
   always @(negedge clk_33) begin
      #1;
      if (nrst)
         sample_chain();
   end

   // Four-phase order on the pixel port
   always @(posedge clk_33) begin
      if (nrst && pix_ack && !ack_q && !req_q) begin
         other_errs++;
         $display("pix_ack rose without pix_req");
      end
      if (nrst && !pix_ack && ack_q && req_q) begin
         other_errs++;
         $display("pix_ack fell while pix_req was still high");
      end
      req_q <= pix_req;
      ack_q <= pix_ack;
   end

   task automatic wait_ack(input logic level, input string what);
      int t;
      t = 0;
      while (pix_ack !== level && t < HS_LIMIT) begin
         @(negedge clk_33);
         t++;
      end
      if (pix_ack !== level)
         abort_run(what);
   endtask

   task automatic wait_edges(input int unsigned n, input int limit, input string what);
      int t;
      t = 0;
      while (sclk_edges < n && t < limit) begin
         @(negedge clk_33);
         t++;
      end
      if (sclk_edges < n)
         abort_run(what);
   endtask

   task automatic send_group(input led_group_t g);
      queue_slices(g);
      pix_data = g;
      pix_req = 1'b1;
      wait_ack(1'b1, "pix_ack did not rise");
      pix_req = 1'b0;
      wait_ack(1'b0, "pix_ack did not fall");
   endtask

   // Random gaps, FIFO-draining pauses and zero-gap bursts
   task automatic stream_groups();
      logic [31:0] r;
      int gap;
      for (int g = 0; g < FRAMES * SEG_PER_FRAME; g++) begin
         r = rand_word();
         if (g == 0 || r[6:4] < 3)
            gap = 0;
         else if (r[3:0] == 0)
            gap = 200 + int'(r[31:8] % 400);
         else
            gap = int'(r[31:8] % 8);
         repeat (gap) @(negedge clk_33);
         send_group(random_group());
      end
   endtask

   initial begin
      nrst = 1'b0;
      pix_req = 1'b0;
      pix_data = '0;
      frame_sync = 1'b0;
      sync_delay = 40 + int'(rand_word() % 64);
      repeat (16) @(negedge clk_33);
      nrst = 1'b1;
      fork
         stream_groups();
         begin
            wait_edges(CFG_EDGES, 500, "boot configuration did not finish");
            repeat (sync_delay) @(negedge clk_33);
            frame_sync = 1'b1;
            sync_sent = 1'b1;
            @(negedge clk_33);
            frame_sync = 1'b0;
         end
      join
      wait_edges(CFG_EDGES + FRAMES * FRAME_EDGES, 20000, "frames did not complete");
      repeat (BLANKING_TIME + 20) @(negedge clk_33);
      // Last LATGS run has no later edge to close it
      if (lat_run != 0)
         check_lat($sformatf("latch run from edge %0d", run_start), lat_at(run_start),
                   run_from(run_start), lat_run);
      if (ref_q.size() != 0) begin
         other_errs++;
         $display("%0d slices never reached the drivers", ref_q.size());
      end
      print_counts();
      if (slice_errs + conf_errs + lat_errs + gap_errs + other_errs == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: led_panel.f
+incdir+include
logic/panel_pkg.sv
logic/drv_pkg.sv
logic/bitplane_slicer.sv
logic/slice_fifo.sv
logic/driver_main_controller.sv
logic/led_panel_top.sv
tests/tb_led_panel.sv

// File: Bender.yml
package:
  name: led_panel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/panel_pkg.sv
      - logic/drv_pkg.sv
      - logic/bitplane_slicer.sv
      - logic/slice_fifo.sv
      - logic/driver_main_controller.sv
      - logic/led_panel_top.sv
  - target: test
    files:
      - tests/tb_led_panel.sv
